// ==== aplic_cfg.svh ====
`ifndef APLIC_CFG_SVH
`define APLIC_CFG_SVH

// Domain geometry
`define APLIC_NR_SRC         32
`define APLIC_ADDR_W         16

// Register map, byte offsets
`define APLIC_DOMAINCFG_OFS  16'h0000
`define APLIC_SOURCECFG_OFS  16'h0004
`define APLIC_SETIP_OFS      16'h1C00
`define APLIC_SETIPNUM_OFS   16'h1CDC
`define APLIC_CLRIP_OFS      16'h1D00
`define APLIC_CLRIPNUM_OFS   16'h1DDC
`define APLIC_SETIE_OFS      16'h1E00
`define APLIC_SETIENUM_OFS   16'h1EDC
`define APLIC_CLRIE_OFS      16'h1F00
`define APLIC_CLRIENUM_OFS   16'h1FDC
`define APLIC_TARGET_OFS     16'h3004

// Source modes
`define APLIC_SM_INACTIVE    3'd0
`define APLIC_SM_DETACHED    3'd1
`define APLIC_SM_EDGE1       3'd4
`define APLIC_SM_EDGE0       3'd5
`define APLIC_SM_LEVEL1      3'd6
`define APLIC_SM_LEVEL0      3'd7

// domaincfg, bit 31 reads as one
`define APLIC_DOMAINCFG_RST  32'h8000_0000
`define APLIC_IE_BIT         8

`endif

// ==== aplic_pkg.sv ====
`include "aplic_cfg.svh"

package aplic_pkg;

  typedef logic [31:0]                        word_t;
  typedef logic [`APLIC_ADDR_W-1:0]           wb_addr_t;
  typedef logic [`APLIC_NR_SRC-1:0]           src_vec_t;
  typedef logic [$clog2(`APLIC_NR_SRC)-1:0]   src_id_t;
  typedef logic [2:0]                         src_mode_t;

  typedef enum logic {
    WB_IDLE,
    WB_ACK
  } wb_state_t;

  // Set and clear by mask or by number, shared by pending and enable
  function automatic src_vec_t set_clr_vec(
    input src_vec_t cur,
    input logic     set_we,
    input logic     setnum_we,
    input logic     clr_we,
    input logic     clrnum_we,
    input word_t    wdat
  );
    src_vec_t nxt;
    logic     num_ok;
    nxt    = cur;
    // Number 0 and out of range numbers do nothing
    num_ok = (wdat != '0) && (wdat < `APLIC_NR_SRC);
    if (set_we) nxt = nxt | wdat;
    if (clr_we) nxt = nxt & ~wdat;
    if (setnum_we && num_ok) nxt[src_id_t'(wdat)] = 1'b1;
    if (clrnum_we && num_ok) nxt[src_id_t'(wdat)] = 1'b0;
    return nxt;
  endfunction

endpackage

// ==== aplic_wb_ctrl.sv ====
`include "aplic_cfg.svh"

module aplic_wb_ctrl
  import aplic_pkg::*;
(
  input  logic     i_clk,
  input  logic     ni_rst,
  input  logic     i_wb_cyc,
  input  logic     i_wb_stb,
  input  logic     i_wb_we,
  input  wb_addr_t i_wb_adr,
  input  word_t    i_wb_dat,
  input  word_t    i_cfg_rdat,
  input  word_t    i_tgt_rdat,
  input  src_vec_t i_ip,
  input  src_vec_t i_ie,
  input  src_vec_t i_rect,
  output logic     o_wb_ack,
  output word_t    o_wb_dat,
  output logic     o_cfg_we,
  output src_id_t  o_cfg_id,
  output logic     o_tgt_we,
  output src_id_t  o_tgt_id,
  output logic     o_setip_we,
  output logic     o_setipnum_we,
  output logic     o_clrip_we,
  output logic     o_clripnum_we,
  output logic     o_setie_we,
  output logic     o_setienum_we,
  output logic     o_clrie_we,
  output logic     o_clrienum_we,
  output word_t    o_wdat,
  output logic     o_dom_ie
);

  // Last source sits 4 * (NR_SRC - 2) above the first
  localparam wb_addr_t CFG_LAST = `APLIC_SOURCECFG_OFS + 16'(4 * (`APLIC_NR_SRC - 2));
  localparam wb_addr_t TGT_LAST = `APLIC_TARGET_OFS + 16'(4 * (`APLIC_NR_SRC - 2));

  wb_state_t state_q;
  wb_addr_t  adr;
  logic      req;
  logic      wr;
  logic      dom_hit;
  logic      cfg_hit;
  logic      tgt_hit;
  logic      dom_ie_q;
  word_t     rdat;

// ================== Decode ========================
  assign adr     = {i_wb_adr[`APLIC_ADDR_W-1:2], 2'b00};
  assign req     = (state_q == WB_IDLE) && i_wb_cyc && i_wb_stb;
  assign wr      = req && i_wb_we;

  assign dom_hit = (adr == `APLIC_DOMAINCFG_OFS);
  assign cfg_hit = (adr >= `APLIC_SOURCECFG_OFS) && (adr <= CFG_LAST);
  assign tgt_hit = (adr >= `APLIC_TARGET_OFS) && (adr <= TGT_LAST);

  assign o_cfg_id = src_id_t'((adr - `APLIC_SOURCECFG_OFS) >> 2) + 1'b1;
  assign o_tgt_id = src_id_t'((adr - `APLIC_TARGET_OFS) >> 2) + 1'b1;

  // One strobe per register, only in the sampling cycle
  assign o_cfg_we      = wr && cfg_hit;
  assign o_tgt_we      = wr && tgt_hit;
  assign o_setip_we    = wr && (adr == `APLIC_SETIP_OFS);
  assign o_setipnum_we = wr && (adr == `APLIC_SETIPNUM_OFS);
  assign o_clrip_we    = wr && (adr == `APLIC_CLRIP_OFS);
  assign o_clripnum_we = wr && (adr == `APLIC_CLRIPNUM_OFS);
  assign o_setie_we    = wr && (adr == `APLIC_SETIE_OFS);
  assign o_setienum_we = wr && (adr == `APLIC_SETIENUM_OFS);
  assign o_clrie_we    = wr && (adr == `APLIC_CLRIE_OFS);
  assign o_clrienum_we = wr && (adr == `APLIC_CLRIENUM_OFS);
  assign o_wdat        = i_wb_dat;

// ================== Read mux ======================
  always_comb begin
    rdat = '0;
    if (dom_hit) begin
      rdat = `APLIC_DOMAINCFG_RST | (word_t'(dom_ie_q) << `APLIC_IE_BIT);
    end else if (cfg_hit) begin
      rdat = i_cfg_rdat;
    end else if (tgt_hit) begin
      rdat = i_tgt_rdat;
    end else begin
      // Num registers and clrie read as zero
      case (adr)
        `APLIC_SETIP_OFS: rdat = i_ip;
        `APLIC_CLRIP_OFS: rdat = i_rect;
        `APLIC_SETIE_OFS: rdat = i_ie;
        default:          rdat = '0;
      endcase
    end
  end

// ================== Bus FSM =======================
  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      state_q  <= WB_IDLE;
      dom_ie_q <= 1'b0;
    end else begin
      case (state_q)
        WB_IDLE: if (i_wb_cyc && i_wb_stb) state_q <= WB_ACK;
        default: state_q <= WB_IDLE;
      endcase
      if (wr && dom_hit) dom_ie_q <= i_wb_dat[`APLIC_IE_BIT];
    end
  end

  always_ff @(posedge i_clk) begin
    if (req) o_wb_dat <= rdat;
  end

  assign o_wb_ack = (state_q == WB_ACK);
  assign o_dom_ie = dom_ie_q;

endmodule

// ==== aplic_src_cfg.sv ====
`include "aplic_cfg.svh"

module aplic_src_cfg
  import aplic_pkg::*;
(
  input  logic     i_clk,
  input  logic     ni_rst,
  input  logic     i_cfg_we,
  input  src_id_t  i_cfg_id,
  input  logic     i_tgt_we,
  input  src_id_t  i_tgt_id,
  input  word_t    i_wdat,
  input  src_vec_t i_src,
  output word_t    o_cfg_rdat,
  output word_t    o_tgt_rdat,
  output src_vec_t o_active,
  output src_vec_t o_level,
  output src_vec_t o_rect
);

  // Entry 0 is never written and stays inactive
  src_mode_t mode_q [`APLIC_NR_SRC];
  word_t     tgt_q  [`APLIC_NR_SRC];
  src_mode_t wmode;
  logic [7:0] wprio;

  // Reserved codes 2 and 3 fold to inactive
  assign wmode = (i_wdat[2:1] == 2'b01) ? `APLIC_SM_INACTIVE : i_wdat[2:0];
  assign wprio = (i_wdat[7:0] == 8'd0) ? 8'd1 : i_wdat[7:0];

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      for (int i = 0; i < `APLIC_NR_SRC; i++) begin
        mode_q[i] <= `APLIC_SM_INACTIVE;
        tgt_q[i]  <= '0;
      end
    end else begin
      if (i_cfg_we) mode_q[i_cfg_id] <= wmode;
      // Hart index and priority only
      if (i_tgt_we && o_active[i_tgt_id]) begin
        tgt_q[i_tgt_id] <= {i_wdat[31:18], 10'd0, wprio};
      end
    end
  end

// ============ Active, level, rectify ==============
  always_comb begin
    for (int i = 0; i < `APLIC_NR_SRC; i++) begin
      o_active[i] = (mode_q[i] != `APLIC_SM_INACTIVE);
      o_level[i]  = (mode_q[i] == `APLIC_SM_LEVEL1) || (mode_q[i] == `APLIC_SM_LEVEL0);
      case (mode_q[i])
        `APLIC_SM_EDGE1,
        `APLIC_SM_LEVEL1: o_rect[i] = i_src[i];
        `APLIC_SM_EDGE0,
        `APLIC_SM_LEVEL0: o_rect[i] = ~i_src[i];
        default:          o_rect[i] = 1'b0;
      endcase
    end
  end

  assign o_cfg_rdat = word_t'(mode_q[i_cfg_id]);
  assign o_tgt_rdat = tgt_q[i_tgt_id];

endmodule

// ==== aplic_pending.sv ====
module aplic_pending
  import aplic_pkg::*;
(
  input  logic     i_clk,
  input  logic     ni_rst,
  input  logic     i_setip_we,
  input  logic     i_setipnum_we,
  input  logic     i_clrip_we,
  input  logic     i_clripnum_we,
  input  word_t    i_wdat,
  input  src_vec_t i_active,
  input  src_vec_t i_rect,
  input  src_vec_t i_level,
  output src_vec_t o_ip
);

  src_vec_t ip_q;
  src_vec_t rect_q;
  src_vec_t wr_ip;
  src_vec_t edge_set;
  src_vec_t ip_d;

  // Register writes first, then source events on top
  assign wr_ip    = set_clr_vec(ip_q, i_setip_we, i_setipnum_we,
                                i_clrip_we, i_clripnum_we, i_wdat);
  assign edge_set = i_rect & ~rect_q;

  always_comb begin
    // Edge and detached sources keep the written state
    ip_d = (wr_ip | edge_set) & ~i_level;
    // Level sources track the input
    ip_d = ip_d | (i_rect & i_level);
    ip_d = ip_d & i_active;
  end

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      ip_q   <= '0;
      rect_q <= '0;
    end else begin
      ip_q   <= ip_d;
      rect_q <= i_rect;
    end
  end

  assign o_ip = ip_q;

endmodule

// ==== aplic_enable.sv ====
module aplic_enable
  import aplic_pkg::*;
(
  input  logic     i_clk,
  input  logic     ni_rst,
  input  logic     i_setie_we,
  input  logic     i_setienum_we,
  input  logic     i_clrie_we,
  input  logic     i_clrienum_we,
  input  word_t    i_wdat,
  input  src_vec_t i_active,
  output src_vec_t o_ie
);

  src_vec_t ie_q;
  src_vec_t ie_d;

  // Inactive sources and bit 0 drop out here
  assign ie_d = set_clr_vec(ie_q, i_setie_we, i_setienum_we,
                            i_clrie_we, i_clrienum_we, i_wdat) & i_active;

  always_ff @(posedge i_clk or negedge ni_rst) begin
    if (!ni_rst) begin
      ie_q <= '0;
    end else begin
      ie_q <= ie_d;
    end
  end

  assign o_ie = ie_q;

endmodule

// ==== aplic_domain.sv ====
module aplic_domain
  import aplic_pkg::*;
(
  input  logic     i_clk,
  input  logic     ni_rst,
  input  logic     i_wb_cyc,
  input  logic     i_wb_stb,
  input  logic     i_wb_we,
  input  wb_addr_t i_wb_adr,
  input  word_t    i_wb_dat,
  output logic     o_wb_ack,
  output word_t    o_wb_dat,
  input  src_vec_t i_src,
  output src_vec_t o_ip,
  output src_vec_t o_ie,
  output logic     o_irq
);

  logic     cfg_we;
  src_id_t  cfg_id;
  logic     tgt_we;
  src_id_t  tgt_id;
  logic     setip_we;
  logic     setipnum_we;
  logic     clrip_we;
  logic     clripnum_we;
  logic     setie_we;
  logic     setienum_we;
  logic     clrie_we;
  logic     clrienum_we;
  word_t    wdat;
  logic     dom_ie;
  word_t    cfg_rdat;
  word_t    tgt_rdat;
  src_vec_t active;
  src_vec_t level;
  src_vec_t rect;

// ================== Bus side ======================
  aplic_wb_ctrl i_aplic_wb_ctrl (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_wb_cyc      (i_wb_cyc),
    .i_wb_stb      (i_wb_stb),
    .i_wb_we       (i_wb_we),
    .i_wb_adr      (i_wb_adr),
    .i_wb_dat      (i_wb_dat),
    .i_cfg_rdat    (cfg_rdat),
    .i_tgt_rdat    (tgt_rdat),
    .i_ip          (o_ip),
    .i_ie          (o_ie),
    .i_rect        (rect),
    .o_wb_ack      (o_wb_ack),
    .o_wb_dat      (o_wb_dat),
    .o_cfg_we      (cfg_we),
    .o_cfg_id      (cfg_id),
    .o_tgt_we      (tgt_we),
    .o_tgt_id      (tgt_id),
    .o_setip_we    (setip_we),
    .o_setipnum_we (setipnum_we),
    .o_clrip_we    (clrip_we),
    .o_clripnum_we (clripnum_we),
    .o_setie_we    (setie_we),
    .o_setienum_we (setienum_we),
    .o_clrie_we    (clrie_we),
    .o_clrienum_we (clrienum_we),
    .o_wdat        (wdat),
    .o_dom_ie      (dom_ie)
  );

// ================== Datapath ======================
  aplic_src_cfg i_aplic_src_cfg (
    .i_clk      (i_clk),
    .ni_rst     (ni_rst),
    .i_cfg_we   (cfg_we),
    .i_cfg_id   (cfg_id),
    .i_tgt_we   (tgt_we),
    .i_tgt_id   (tgt_id),
    .i_wdat     (wdat),
    .i_src      (i_src),
    .o_cfg_rdat (cfg_rdat),
    .o_tgt_rdat (tgt_rdat),
    .o_active   (active),
    .o_level    (level),
    .o_rect     (rect)
  );

  aplic_pending i_aplic_pending (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_setip_we    (setip_we),
    .i_setipnum_we (setipnum_we),
    .i_clrip_we    (clrip_we),
    .i_clripnum_we (clripnum_we),
    .i_wdat        (wdat),
    .i_active      (active),
    .i_rect        (rect),
    .i_level       (level),
    .o_ip          (o_ip)
  );

  aplic_enable i_aplic_enable (
    .i_clk         (i_clk),
    .ni_rst        (ni_rst),
    .i_setie_we    (setie_we),
    .i_setienum_we (setienum_we),
    .i_clrie_we    (clrie_we),
    .i_clrienum_we (clrienum_we),
    .i_wdat        (wdat),
    .i_active      (active),
    .o_ie          (o_ie)
  );

  // Any enabled pending source while the domain is enabled
  assign o_irq = dom_ie & |(o_ip & o_ie);

endmodule

// ==== aplic_props.sv ====
module aplic_props
  import aplic_pkg::*;
(
  input logic     i_clk,
  input logic     ni_rst,
  input logic     i_wb_cyc,
  input logic     i_wb_stb,
  input logic     i_wb_ack,
  input src_vec_t i_ip,
  input src_vec_t i_ie,
  input src_vec_t i_active
);

  int unsigned fail_cnt = 0;

  // Ack only follows a sampled request
  ack_after_req: assert property (@(posedge i_clk) disable iff (!ni_rst)
    $rose(i_wb_ack) |-> $past(i_wb_cyc && i_wb_stb))
    else begin
      fail_cnt++;
      $error("ack rose without a request in the previous cycle");
    end

  ack_one_cycle: assert property (@(posedge i_clk) disable iff (!ni_rst)
    i_wb_ack |=> !i_wb_ack)
    else begin
      fail_cnt++;
      $error("ack lasted two cycles");
    end

  // Source 0 does not exist
  no_src_zero: assert property (@(posedge i_clk) disable iff (!ni_rst)
    !i_ip[0] && !i_ie[0])
    else begin
      fail_cnt++;
      $error("bit 0 of ip or ie is set");
    end

  // Enable is masked by the modes of the cycle before
  ie_only_active: assert property (@(posedge i_clk) disable iff (!ni_rst)
    (i_ie & ~$past(i_active)) == '0)
    else begin
      fail_cnt++;
      $error("ie set for an inactive source");
    end

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
  output logic o_clk,
  output logic no_rst
);

  // 20 unit period
  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  // Reset held low for two rising edges
  initial begin
    no_rst = 1'b0;
    repeat (2) @(posedge o_clk);
    #2 no_rst = 1'b1;
  end

endmodule

// ==== tb_aplic.sv ====
`include "aplic_cfg.svh"

module tb_aplic
  import aplic_pkg::*;
();

  // Stimulus runs for about 1050 cycles
  localparam int MAX_CYCLES = 4000;

  logic     clk;
  logic     rst_n;
  logic     wb_cyc;
  logic     wb_stb;
  logic     wb_we;
  wb_addr_t wb_adr;
  word_t    wb_dat;
  logic     wb_ack;
  word_t    wb_rdat;
  src_vec_t src;
  src_vec_t ip;
  src_vec_t ie;
  logic     irq;

  logic [15:0] lfsr_q;
  int unsigned checks = 0;
  int unsigned errors = 0;
  int unsigned cycles = 0;

  // Reference model state
  logic      m_dom_ie;
  src_mode_t m_mode [32];
  word_t     m_tgt  [32];
  src_vec_t  m_ip;
  src_vec_t  m_ie;
  src_vec_t  m_rect_q;

  tb_clk_gen i_tb_clk_gen (
    .o_clk  (clk),
    .no_rst (rst_n)
  );

  aplic_domain i_aplic_domain (
    .i_clk    (clk),
    .ni_rst   (rst_n),
    .i_wb_cyc (wb_cyc),
    .i_wb_stb (wb_stb),
    .i_wb_we  (wb_we),
    .i_wb_adr (wb_adr),
    .i_wb_dat (wb_dat),
    .o_wb_ack (wb_ack),
    .o_wb_dat (wb_rdat),
    .i_src    (src),
    .o_ip     (ip),
    .o_ie     (ie),
    .o_irq    (irq)
  );

  bind aplic_domain aplic_props i_aplic_props (
    .i_clk    (i_clk),
    .ni_rst   (ni_rst),
    .i_wb_cyc (i_wb_cyc),
    .i_wb_stb (i_wb_stb),
    .i_wb_ack (o_wb_ack),
    .i_ip     (o_ip),
    .i_ie     (o_ie),
    .i_active (active)
  );

// ================== Random and compare ============
  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (b) lfsr_q = lfsr_q ^ 16'hB400;
    return b;
  endfunction

  function automatic word_t rand_word(input int n);
    word_t w;
    w = '0;
    for (int i = 0; i < n; i++) w[i] = lfsr_bit();
    return w;
  endfunction

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_vec(input string name, input src_vec_t got, input src_vec_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

// ================== Reference model ===============
  // Source number behind a register address or 0 outside the array
  function automatic int src_index(input wb_addr_t adr, input wb_addr_t base);
    int ofs;
    ofs = int'(adr) - int'(base);
    if (ofs < 0 || ofs > 4 * 30 || ofs % 4 != 0) return 0;
    return ofs / 4 + 1;
  endfunction

  function automatic wb_addr_t cfg_adr(input int k);
    return `APLIC_SOURCECFG_OFS + wb_addr_t'(4 * (k - 1));
  endfunction

  function automatic wb_addr_t tgt_adr(input int k);
    return `APLIC_TARGET_OFS + wb_addr_t'(4 * (k - 1));
  endfunction

  function automatic src_vec_t model_rect();
    src_vec_t r;
    for (int i = 0; i < 32; i++) begin
      if (m_mode[i] == `APLIC_SM_EDGE1 || m_mode[i] == `APLIC_SM_LEVEL1) r[i] = src[i];
      else if (m_mode[i] == `APLIC_SM_EDGE0 || m_mode[i] == `APLIC_SM_LEVEL0) r[i] = !src[i];
      else r[i] = 1'b0;
    end
    return r;
  endfunction

  function automatic word_t model_read(input wb_addr_t adr);
    int c;
    int t;
    c = src_index(adr, `APLIC_SOURCECFG_OFS);
    t = src_index(adr, `APLIC_TARGET_OFS);
    if (adr == `APLIC_DOMAINCFG_OFS) return {1'b1, 22'd0, m_dom_ie, 8'd0};
    if (c != 0) return word_t'(m_mode[c]);
    if (t != 0) return m_tgt[t];
    if (adr == `APLIC_SETIP_OFS) return m_ip;
    if (adr == `APLIC_CLRIP_OFS) return model_rect();
    if (adr == `APLIC_SETIE_OFS) return m_ie;
    return '0;
  endfunction

  // Model steps with any write sampled at the next clock edge
  task automatic tick(input logic wr, input wb_addr_t adr, input word_t dat);
    src_vec_t rect;
    src_vec_t act;
    src_vec_t wip;
    src_vec_t wie;
    logic     num_ok;
    int       c;
    int       t;
    rect   = model_rect();
    wip    = m_ip;
    wie    = m_ie;
    num_ok = wr && (dat != 0) && (dat < 32);
    c      = wr ? src_index(adr, `APLIC_SOURCECFG_OFS) : 0;
    t      = wr ? src_index(adr, `APLIC_TARGET_OFS) : 0;
    for (int i = 0; i < 32; i++) act[i] = (m_mode[i] != `APLIC_SM_INACTIVE);
    if (wr && adr == `APLIC_SETIP_OFS) wip = wip | dat;
    if (wr && adr == `APLIC_CLRIP_OFS) wip = wip & ~dat;
    if (num_ok && adr == `APLIC_SETIPNUM_OFS) wip[dat[4:0]] = 1'b1;
    if (num_ok && adr == `APLIC_CLRIPNUM_OFS) wip[dat[4:0]] = 1'b0;
    if (wr && adr == `APLIC_SETIE_OFS) wie = wie | dat;
    if (wr && adr == `APLIC_CLRIE_OFS) wie = wie & ~dat;
    if (num_ok && adr == `APLIC_SETIENUM_OFS) wie[dat[4:0]] = 1'b1;
    if (num_ok && adr == `APLIC_CLRIENUM_OFS) wie[dat[4:0]] = 1'b0;
    for (int i = 0; i < 32; i++) begin
      if (m_mode[i] == `APLIC_SM_LEVEL1 || m_mode[i] == `APLIC_SM_LEVEL0) m_ip[i] = rect[i];
      else m_ip[i] = act[i] & (wip[i] | (rect[i] & !m_rect_q[i]));
    end
    m_ie     = wie & act;
    m_rect_q = rect;
    if (wr && adr == `APLIC_DOMAINCFG_OFS) m_dom_ie = dat[`APLIC_IE_BIT];
    // Reserved codes 2 and 3 store inactive
    if (c != 0) begin
      if (dat[2:0] == 3'd2 || dat[2:0] == 3'd3) m_mode[c] = `APLIC_SM_INACTIVE;
      else m_mode[c] = dat[2:0];
    end
    if (t != 0 && act[t]) begin
      m_tgt[t] = {dat[31:18], 10'd0, ((dat[7:0] == 8'd0) ? 8'd1 : dat[7:0])};
    end
    @(posedge clk);
    #2;
    check_vec("o_ip", ip, m_ip);
    check_vec("o_ie", ie, m_ie);
    check_irq("o_irq", irq, m_dom_ie & |(m_ip & m_ie));
  endtask

// ================== Bus master ====================
  task automatic bus_xfer(input logic we, input wb_addr_t adr, input word_t dat);
    word_t       exp;
    int unsigned waits;
    exp    = model_read(adr);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = we;
    wb_adr = adr;
    wb_dat = dat;
    tick(we, adr, dat);
    waits = 0;
    while (wb_ack !== 1'b1) begin
      waits++;
      tick(1'b0, adr, dat);
    end
    if (waits != 0) begin
      errors++;
      $display("Bus ack at address %h came %0d cycles late", adr, waits);
    end
    if (!we) check_word("o_wb_dat", wb_rdat, exp);
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    tick(1'b0, adr, dat);
    check_irq("o_wb_ack", wb_ack, 1'b0);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("Timeout after %0d cycles, the test did not finish", cycles);
      $display("Something failed");
      $finish;
    end
  end

// ================== Stimulus ======================
  initial begin : stimulus
    word_t       w;
    int          k;
    int unsigned fails;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat   = '0;
    src      = '0;
    lfsr_q   = 16'd61806;
    m_dom_ie = 1'b0;
    m_ip     = '0;
    m_ie     = '0;
    m_rect_q = '0;
    for (int i = 0; i < 32; i++) begin
      m_mode[i] = `APLIC_SM_INACTIVE;
      m_tgt[i]  = '0;
    end
    @(posedge rst_n);
    @(posedge clk);
    #2;
    check_vec("o_ip", ip, '0);
    check_vec("o_ie", ie, '0);
    check_irq("o_irq", irq, 1'b0);
    check_irq("o_wb_ack", wb_ack, 1'b0);

    // domaincfg keeps only the IE bit
    repeat (6) begin
      bus_xfer(1'b1, `APLIC_DOMAINCFG_OFS, rand_word(32));
      bus_xfer(1'b0, `APLIC_DOMAINCFG_OFS, '0);
    end

    for (k = 1; k < 32; k++) begin
      bus_xfer(1'b1, cfg_adr(k), rand_word(32));
      bus_xfer(1'b0, cfg_adr(k), '0);
    end

    // All detached so pending only moves by register writes
    for (k = 1; k < 32; k++) bus_xfer(1'b1, cfg_adr(k), 32'(`APLIC_SM_DETACHED));
    repeat (60) begin
      case (rand_word(2))
        0:       bus_xfer(1'b1, `APLIC_SETIP_OFS, rand_word(32));
        1:       bus_xfer(1'b1, `APLIC_CLRIP_OFS, rand_word(32));
        2:       bus_xfer(1'b1, `APLIC_SETIPNUM_OFS, rand_word(5));
        default: bus_xfer(1'b1, `APLIC_CLRIPNUM_OFS, rand_word(5));
      endcase
      bus_xfer(1'b0, `APLIC_SETIP_OFS, '0);
    end
    bus_xfer(1'b1, `APLIC_SETIPNUM_OFS, '0);
    bus_xfer(1'b1, `APLIC_CLRIPNUM_OFS, '0);
    bus_xfer(1'b0, `APLIC_SETIP_OFS, '0);

    // Mixed modes with random wired sources
    for (k = 1; k < 32; k++) bus_xfer(1'b1, cfg_adr(k), rand_word(3));
    repeat (80) begin
      src = rand_word(32);
      if (lfsr_bit()) bus_xfer(1'b0, `APLIC_CLRIP_OFS, '0);
      else tick(1'b0, '0, '0);
      if (lfsr_bit()) bus_xfer(1'b0, `APLIC_SETIP_OFS, '0);
    end

    // Enables, domain IE and mode changes interleaved
    bus_xfer(1'b1, `APLIC_DOMAINCFG_OFS, 32'h100);
    repeat (100) begin
      src = rand_word(32);
      case (rand_word(3))
        0: bus_xfer(1'b1, `APLIC_SETIE_OFS, rand_word(32));
        1: bus_xfer(1'b1, `APLIC_CLRIE_OFS, rand_word(32));
        2: bus_xfer(1'b1, `APLIC_SETIENUM_OFS, rand_word(5));
        3: bus_xfer(1'b1, `APLIC_CLRIENUM_OFS, rand_word(5));
        4: bus_xfer(1'b1, `APLIC_SETIP_OFS, rand_word(32));
        5: bus_xfer(1'b1, `APLIC_DOMAINCFG_OFS, rand_word(32));
        6: begin
          k = int'(rand_word(5));
          if (k == 0) k = 1;
          bus_xfer(1'b1, cfg_adr(k), rand_word(3));
        end
        default: bus_xfer(1'b0, `APLIC_SETIE_OFS, '0);
      endcase
    end

    // Targets with some priority 0 and inactive sources left unchanged
    for (k = 1; k < 32; k++) begin
      w = rand_word(32);
      if (lfsr_bit()) w[7:0] = 8'd0;
      bus_xfer(1'b1, tgt_adr(k), w);
      bus_xfer(1'b0, tgt_adr(k), '0);
    end

    // Hole in the map
    bus_xfer(1'b1, 16'h2000, rand_word(32));
    bus_xfer(1'b0, 16'h2000, '0);

    fails = i_aplic_domain.i_aplic_props.fail_cnt;
    $display("Checks: %0d  errors: %0d  assertion failures: %0d", checks, errors, fails);
    if (errors == 0 && fails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
aplic_pkg.sv
aplic_wb_ctrl.sv
aplic_src_cfg.sv
aplic_pending.sv
aplic_enable.sv
aplic_domain.sv
aplic_props.sv
tb_clk_gen.sv
tb_aplic.sv

// ==== Makefile ====
TOP := tb_aplic

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
